/* Makefile */
# Verilator build and run for the framebuffer fizzlefade testbench
# usage: make, make lint, make clean, e.g. make LOG=run.log

VERILATOR  ?= verilator
TB_TOP     ?= tb_framebuffer_top
RTL_TOP    ?= framebuffer_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_framebuffer_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the fizzlefade framebuffer, rebuilds pixel positions
// from the VGA syncs and checks timing, image and fade with assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_framebuffer_top;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 4;
    localparam int fade_wait    = 2;  // frame 0 is only partly seen by the model
    localparam int fade_rate    = 2;

    // expected VGA timing at the ports
    localparam int h_total_exp = 800;
    localparam int h_sync_exp  = 96;
    localparam int v_total_exp = 525;
    localparam int v_sync_exp  = 2;
    localparam int hs_rise_sx  = 752;  // first position after the hsync pulse
    localparam int vs_rise_sy  = 492;  // first line after the vsync pulse
    localparam int frame_clks  = h_total_exp * v_total_exp;
    localparam int img_w       = 160;
    localparam int img_h       = 120;
    localparam int img_pixels  = img_w * img_h;
    localparam int watchdog_ns = 8 * frame_clks * clk_period;

    localparam fb_pkg::colour_t fade_col = fb_pkg::palette[15];

    logic            clk_pix;
    logic            rst_n;
    logic            vga_hsync;
    logic            vga_vsync;
    logic [3:0]      vga_r;
    logic [3:0]      vga_g;
    logic [3:0]      vga_b;
    logic            fade_done;
    fb_pkg::colour_t pix;

    // pixel-stream model, registered part
    logic hs_q;
    logic vs_q;
    logic h_lock;
    logic v_lock;
    logic h_fell;
    logic v_fell;
    logic done_seen;
    logic run_over;
    int   sx_q;
    int   sy_q;
    int   hs_low;
    int   hs_per;
    int   vs_low;
    int   vs_per;
    int   frame_num;
    int   fade_cnt;
    int   fade_cnt_last;
    int   final_num;
    int   pix_checked;

    // pixel-stream model, current sample
    logic            h_rise;
    logic            h_fall;
    logic            v_rise;
    logic            v_fall;
    logic            in_img;
    logic            in_final;
    logic            frame_end;
    logic            is_fade;
    logic            reset_idle;
    int              cur_sx;
    int              cur_sy;
    fb_pkg::cidx_t   stripe_idx;
    fb_pkg::colour_t stripe_col;

    int errors = 0;

    framebuffer_top #(
        .fade_wait_frames (fade_wait),
        .fade_rate_clks   (fade_rate)
    ) UUT (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .fade_done (fade_done)
    );

    always #(clk_period / 2) clk_pix = ~clk_pix;

    assign pix = {vga_r, vga_g, vga_b};

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    task automatic value_mismatch(input string what, input int got, input int exp);
        errors++;
        $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    endtask

    task automatic pixel_mismatch(input string what, input int x, input int y,
                                  input int frame, input logic [11:0] got,
                                  input logic [11:0] exp);
        errors++;
        $display("[FAIL] %0d ns: %s, frame %0d pixel (%0d,%0d) shows %03h, expected %03h",
                 $time, what, frame, x, y, got, exp);
    endtask

    task automatic print_counts();
        $display("summary: %0d errors, %0d frames, %0d image pixels compared",
                 errors, frame_num, pix_checked);
    endtask

    // position of the current output sample, from the sync edges
    always_comb begin
        h_rise = vga_hsync && !hs_q;
        h_fall = !vga_hsync && hs_q;
        v_rise = vga_vsync && !vs_q;
        v_fall = !vga_vsync && vs_q;
        if (h_rise) cur_sx = hs_rise_sx;
        else if (sx_q == h_total_exp - 1) cur_sx = 0;
        else cur_sx = sx_q + 1;
        if (v_rise) cur_sy = vs_rise_sy;
        else if (cur_sx == 0) cur_sy = (sy_q == v_total_exp - 1) ? 0 : sy_q + 1;
        else cur_sy = sy_q;
        in_img     = (cur_sx < img_w) && (cur_sy < img_h);
        stripe_idx = fb_pkg::cidx_t'((cur_sx / 10) % 16);  // 10 pixel stripes
        stripe_col = fb_pkg::palette[stripe_idx];
        frame_end  = v_lock && (cur_sx == h_total_exp - 1) && (cur_sy == v_total_exp - 1);
        in_final   = v_lock && (final_num != 0) && (frame_num == final_num);
        is_fade    = v_lock && in_img && (pix == fade_col);
        reset_idle = vga_hsync && vga_vsync && (pix == '0) && !fade_done;
    end

    always @(posedge clk_pix) begin
        if (!rst_n) begin
            hs_q          <= 1'b1;
            vs_q          <= 1'b1;
            h_lock        <= 1'b0;
            v_lock        <= 1'b0;
            h_fell        <= 1'b0;
            v_fell        <= 1'b0;
            done_seen     <= 1'b0;
            run_over      <= 1'b0;
            sx_q          <= 0;
            sy_q          <= 0;
            hs_low        <= 0;
            hs_per        <= 0;
            vs_low        <= 0;
            vs_per        <= 0;
            frame_num     <= 0;
            fade_cnt      <= 0;
            fade_cnt_last <= 0;
            final_num     <= 0;
            pix_checked   <= 0;
        end else begin
            hs_q <= vga_hsync;
            vs_q <= vga_vsync;
            sx_q <= cur_sx;
            sy_q <= cur_sy;
            if (h_rise) h_lock <= 1'b1;
            if (v_rise && h_lock) v_lock <= 1'b1;  // position fully known from here
            if (h_fall) h_fell <= 1'b1;
            if (v_fall) v_fell <= 1'b1;
            if (fade_done) done_seen <= 1'b1;
            hs_low <= vga_hsync ? 0 : hs_low + 1;
            vs_low <= vga_vsync ? 0 : vs_low + 1;
            hs_per <= h_fall ? 1 : hs_per + 1;
            vs_per <= v_fall ? 1 : vs_per + 1;
            if (v_lock && in_img) pix_checked <= pix_checked + 1;
            if (frame_end) begin
                frame_num     <= frame_num + 1;
                fade_cnt      <= 0;
                fade_cnt_last <= fade_cnt;
                // first whole frame after fade_done
                if (final_num == 0 && (done_seen || fade_done)) final_num <= frame_num + 1;
                if (in_final) run_over <= 1'b1;
            end else if (is_fade) begin
                fade_cnt <= fade_cnt + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk_pix) !rst_n |=> reset_idle)
        else flag_error("outputs left their reset values while rst_n was low");
    a_reset_after: assert property (@(posedge clk_pix) !rst_n |-> ##2 reset_idle)
        else flag_error("outputs left their reset values in the cycle after reset");

    a_hs_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        h_rise |-> hs_low == h_sync_exp)
        else value_mismatch("hsync low time", $sampled(hs_low), h_sync_exp);
    a_hs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        h_fall && h_fell |-> hs_per == h_total_exp)
        else value_mismatch("hsync period", $sampled(hs_per), h_total_exp);
    a_vs_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_rise |-> vs_low == v_sync_exp * h_total_exp)
        else value_mismatch("vsync low time", $sampled(vs_low), v_sync_exp * h_total_exp);
    a_vs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_fall && v_fell |-> vs_per == frame_clks)
        else value_mismatch("vsync period", $sampled(vs_per), frame_clks);
    a_vs_align: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_rise && h_lock |-> cur_sx == 0)
        else value_mismatch("line position at vsync end", $sampled(cur_sx), 0);

    a_border: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_lock && !in_img |-> pix == '0)
        else pixel_mismatch("border not black", $sampled(cur_sx), $sampled(cur_sy),
                            $sampled(frame_num), $sampled(pix), 12'h000);
    a_image: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_lock && frame_num == 1 && in_img |-> pix == stripe_col)
        else pixel_mismatch("initial image", $sampled(cur_sx), $sampled(cur_sy),
                            $sampled(frame_num), $sampled(pix), $sampled(stripe_col));
    a_fading: assert property (@(posedge clk_pix) disable iff (!rst_n)
        v_lock && frame_num >= 2 && in_img |-> pix == stripe_col || pix == fade_col)
        else pixel_mismatch("neither stripe nor fade colour", $sampled(cur_sx),
                            $sampled(cur_sy), $sampled(frame_num), $sampled(pix),
                            $sampled(stripe_col));
    a_final: assert property (@(posedge clk_pix) disable iff (!rst_n)
        in_final && in_img |-> pix == fade_col)
        else pixel_mismatch("pixel not faded", $sampled(cur_sx), $sampled(cur_sy),
                            $sampled(frame_num), $sampled(pix), fade_col);

    a_fade_monotone: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_end && frame_num >= 2 |-> fade_cnt >= fade_cnt_last)
        else value_mismatch("faded pixel count", $sampled(fade_cnt), $sampled(fade_cnt_last));
    a_fade_full: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_end && in_final |-> fade_cnt == img_pixels)
        else value_mismatch("faded pixels in final frame", $sampled(fade_cnt), img_pixels);
    a_done_holds: assert property (@(posedge clk_pix) disable iff (!rst_n)
        done_seen |-> fade_done)
        else flag_error("fade_done dropped after it had risen");

    initial begin
        void'($urandom(6));
        clk_pix = 1'b0;
        rst_n   = 1'b0;
        repeat (reset_cycles) @(negedge clk_pix);
        rst_n = 1'b1;
        wait (run_over);
        @(negedge clk_pix);  // let the last assertion actions settle
        print_counts();
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // fade and final frame fit well inside eight frame times
    initial begin
        #(watchdog_ns);
        $display("timeout: the final faded frame was not reached in 8 frame times");
        print_counts();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/video_pkg.sv
hdl/fb_pkg.sv
hdl/disp_if.sv
hdl/display_timing.sv
hdl/fb_bram.sv
hdl/fizzle_fader.sv
hdl/fb_scanout.sv
hdl/framebuffer_top.sv
dv/tb_framebuffer_top.sv

/* hdl/disp_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display timing bundle, driven by the timing generator and read by
// the scanout path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

interface disp_if;

    video_pkg::coord_t sx;  // pixel position in line
    video_pkg::coord_t sy;  // line position in frame
    logic hsync;            // active low
    logic vsync;            // active low
    logic de;               // visible area
    logic frame;            // one cycle at sx == 0, sy == 0

    modport source (
        output sx, sy, hsync, vsync, de, frame
    );

    modport sink (
        input sx, sy, hsync, vsync, de, frame
    );

endinterface

`default_nettype wire

/* hdl/display_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 timing generator, one position per pixel clock, with syncs,
// data enable and a start of frame strobe on the disp_if bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module display_timing (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    disp_if.source    disp
);

    localparam video_pkg::coord_t h_last   = video_pkg::coord_t'(video_pkg::h_total - 1);
    localparam video_pkg::coord_t v_last   = video_pkg::coord_t'(video_pkg::v_total - 1);
    localparam video_pkg::coord_t hs_start =
        video_pkg::coord_t'(video_pkg::h_active + video_pkg::h_front);
    localparam video_pkg::coord_t hs_end   =
        video_pkg::coord_t'(video_pkg::h_active + video_pkg::h_front + video_pkg::h_sync - 1);
    localparam video_pkg::coord_t vs_start =
        video_pkg::coord_t'(video_pkg::v_active + video_pkg::v_front);
    localparam video_pkg::coord_t vs_end   =
        video_pkg::coord_t'(video_pkg::v_active + video_pkg::v_front + video_pkg::v_sync - 1);

    // position counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            disp.sx <= '0;
            disp.sy <= '0;
        end else if (disp.sx == h_last) begin
            disp.sx <= '0;
            disp.sy <= (disp.sy == v_last) ? '0 : disp.sy + 1'b1;  // next line
        end else begin
            disp.sx <= disp.sx + 1'b1;
        end
    end

    // decoded straight from the counters, so syncs line up with sx/sy
    always_comb begin
        disp.hsync = !(disp.sx >= hs_start && disp.sx <= hs_end);
        disp.vsync = !(disp.sy >= vs_start && disp.sy <= vs_end);
        disp.de    = (disp.sx < video_pkg::coord_t'(video_pkg::h_active)) &&
                     (disp.sy < video_pkg::coord_t'(video_pkg::v_active));
        disp.frame = (disp.sx == '0) && (disp.sy == '0);
    end

    // line length never exceeds the total
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        disp.sx < video_pkg::coord_t'(video_pkg::h_total)
    );

endmodule

`default_nettype wire

/* hdl/fb_bram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// simple dual-port framebuffer of colour indices, one write and one
// registered read per clock, preloaded with vertical stripes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module fb_bram (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire fb_pkg::fb_addr_t waddr,
    input  wire fb_pkg::cidx_t    wdata,
    input  wire fb_pkg::fb_addr_t raddr,
    output fb_pkg::cidx_t         rdata
);

    fb_pkg::cidx_t mem [fb_pkg::fb_pixels];

    // stripes 10 pixels wide, index cycles through the palette
    initial begin
        for (int y = 0; y < fb_pkg::fb_height; y++) begin
            for (int x = 0; x < fb_pkg::fb_width; x++) begin
                mem[y * fb_pkg::fb_width + x] = fb_pkg::cidx_t'((x / 10) % 16);
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];  // one cycle read latency
    end

    // fader must skip lfsr values past the image
    a_waddr_range: assert property (
        @(posedge clk_pix)
        we |-> waddr < fb_pkg::fb_addr_t'(fb_pkg::fb_pixels)
    );

endmodule

`default_nettype wire

/* hdl/fb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer geometry, colour types, palette and fade definitions
// used by the memory, the fader and the scanout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fb_pkg;

    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_pixels = fb_width * fb_height;  // 19200

    typedef logic [14:0] fb_addr_t;  // 2^15 > 19200
    typedef logic [3:0]  cidx_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colour_t;

    // 16 colour lookup table, 0 is black and 15 is white
    localparam colour_t palette [16] = '{
        12'h000, 12'h225, 12'h725, 12'h085,
        12'ha53, 12'h555, 12'hccc, 12'hffe,
        12'hf04, 12'hfa0, 12'hfe2, 12'h0e3,
        12'h2af, 12'h879, 12'hf7a, 12'hfff
    };

    localparam cidx_t fade_cidx = 4'd15;

    // galois form of x^15 + x^14 + 1, maximal length
    localparam logic [14:0] lfsr_taps = 15'b110_0000_0000_0000;

    typedef enum logic [1:0] {
        fs_wait,
        fs_fade,
        fs_done
    } fade_state_e;

endpackage

`default_nettype wire

/* hdl/fb_scanout.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer scanout, reads the top-left 160x120 area in raster order,
// maps indices through the palette and delay-matches the syncs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module fb_scanout (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    disp_if.sink                  disp,
    output fb_pkg::fb_addr_t      fb_raddr,
    input  wire fb_pkg::cidx_t    fb_rdata,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic [3:0]            vga_r,
    output logic [3:0]            vga_g,
    output logic [3:0]            vga_b
);

    // bram read and index register ahead of the output register
    localparam int lat = 2;
    localparam fb_pkg::fb_addr_t last_addr = fb_pkg::fb_addr_t'(fb_pkg::fb_pixels - 1);

    logic               paint;
    fb_pkg::fb_addr_t   addr_q;
    fb_pkg::cidx_t      cidx_q;
    fb_pkg::colour_t    colr;
    logic [lat-1:0]     paint_sr;
    logic [lat-1:0]     hsync_sr;
    logic [lat-1:0]     vsync_sr;

    always_comb begin
        paint = disp.de &&
                (disp.sx < video_pkg::coord_t'(fb_pkg::fb_width)) &&
                (disp.sy < video_pkg::coord_t'(fb_pkg::fb_height));
        // address for the current pixel, forced to 0 on the frame strobe
        fb_raddr = disp.frame ? '0 : addr_q;
    end

    // wraps after the last pixel so it is already 0 at the next frame
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (paint) begin
            addr_q <= (fb_raddr == last_addr) ? '0 : fb_raddr + 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        cidx_q <= fb_rdata;  // breaks bram to palette path
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            paint_sr <= '0;
            hsync_sr <= '1;  // syncs idle high
            vsync_sr <= '1;
        end else begin
            paint_sr <= {paint, paint_sr[lat-1:1]};
            hsync_sr <= {disp.hsync, hsync_sr[lat-1:1]};
            vsync_sr <= {disp.vsync, vsync_sr[lat-1:1]};
        end
    end

    // black outside the image
    always_comb colr = paint_sr[0] ? fb_pkg::palette[cidx_q] : '0;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_sr[0];
            vga_vsync <= vsync_sr[0];
            vga_r     <= colr.r;
            vga_g     <= colr.g;
            vga_b     <= colr.b;
        end
    end

    // read address must land inside the image
    a_raddr_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fb_raddr < fb_pkg::fb_addr_t'(fb_pkg::fb_pixels)
    );

endmodule

`default_nettype wire

/* hdl/fizzle_fader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fizzlefade controller, waits a number of frames then walks a 15-bit
// LFSR over the framebuffer and paints each pixel with the fade colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module fizzle_fader #(
    parameter int fade_wait_frames = 600,   // whole frames before fading
    parameter int fade_rate_clks   = 3200   // pixel clocks per lfsr step
) (
    input  wire logic        clk_pix,
    input  wire logic        rst_n,
    input  wire logic        frame,
    output logic             fb_we,
    output fb_pkg::fb_addr_t fb_waddr,
    output fb_pkg::cidx_t    fb_wdata,
    output logic             fade_done
);

    localparam int wait_w = $clog2(fade_wait_frames + 2);
    localparam int rate_w = $clog2(fade_rate_clks + 1);
    localparam logic [14:0] lfsr_seed = 15'd1;

    fb_pkg::fade_state_e state;
    logic [wait_w-1:0]   frame_cnt;
    logic [rate_w-1:0]   rate_cnt;
    logic [14:0]         lfsr;
    logic [14:0]         lfsr_next;
    logic                step;

    always_comb begin
        step      = (state == fb_pkg::fs_fade) && (rate_cnt == rate_w'(fade_rate_clks - 1));
        lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ fb_pkg::lfsr_taps) : (lfsr >> 1);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state     <= fb_pkg::fs_wait;
            frame_cnt <= '0;
            rate_cnt  <= '0;
            lfsr      <= lfsr_seed;
            fb_we     <= 1'b0;
            fade_done <= 1'b0;
        end else begin
            fb_we <= 1'b0;
            case (state)
                fb_pkg::fs_wait: begin
                    // first strobe opens frame 0, so compare before counting
                    if (frame) begin
                        if (frame_cnt == wait_w'(fade_wait_frames)) begin
                            state <= fb_pkg::fs_fade;
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                fb_pkg::fs_fade: begin
                    rate_cnt <= step ? '0 : rate_cnt + 1'b1;
                    if (step) begin
                        lfsr  <= lfsr_next;
                        // lfsr runs 1..32767, addresses past the image are skipped
                        fb_we <= (lfsr - 1'b1) < fb_pkg::fb_addr_t'(fb_pkg::fb_pixels);
                        if (lfsr_next == lfsr_seed) begin  // full cycle visited
                            state     <= fb_pkg::fs_done;
                            fade_done <= 1'b1;
                        end
                    end
                end
                fb_pkg::fs_done: begin
                    fade_done <= 1'b1;
                end
                default: state <= fb_pkg::fs_wait;
            endcase
        end
    end

    // write address taken from the value before the step
    always_ff @(posedge clk_pix) begin
        if (step) fb_waddr <= lfsr - 1'b1;
    end

    assign fb_wdata = fb_pkg::fade_cidx;

    // zero would lock the lfsr up and the fade would never finish
    a_lfsr_nonzero: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        lfsr != '0
    );

endmodule

`default_nettype wire

/* hdl/framebuffer_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer display with fizzlefade, 640x480 VGA output on plain ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module framebuffer_top #(
    parameter int fade_wait_frames = 600,
    parameter int fade_rate_clks   = 3200
) (
    input  wire logic  clk_pix,
    input  wire logic  rst_n,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       fade_done
);

    disp_if disp ();

    // framebuffer ports
    logic             fb_we;
    fb_pkg::fb_addr_t fb_waddr;
    fb_pkg::cidx_t    fb_wdata;
    fb_pkg::fb_addr_t fb_raddr;
    fb_pkg::cidx_t    fb_rdata;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp)
    );

    fizzle_fader #(
        .fade_wait_frames (fade_wait_frames),
        .fade_rate_clks   (fade_rate_clks)
    ) u_fader (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .frame     (disp.frame),
        .fb_we     (fb_we),
        .fb_waddr  (fb_waddr),
        .fb_wdata  (fb_wdata),
        .fade_done (fade_done)
    );

    fb_bram u_bram (
        .clk_pix (clk_pix),
        .we      (fb_we),
        .waddr   (fb_waddr),
        .wdata   (fb_wdata),
        .raddr   (fb_raddr),
        .rdata   (fb_rdata)
    );

    fb_scanout u_scanout (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .disp      (disp),
        .fb_raddr  (fb_raddr),
        .fb_rdata  (fb_rdata),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

/* hdl/video_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 display timing constants and the screen coordinate type,
// shared by the timing generator and the scanout path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package video_pkg;

    // horizontal timing in pixels
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800

    // vertical timing in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525

    // 0..799 fits in 10 bits
    typedef logic [9:0] coord_t;

endpackage

`default_nettype wire
